// ==== Bender.yml ====
package:
  name: soc_fabric

sources:
  - include_dirs:
      - .
    files:
      - soc_pkg.sv
      - wb_rr_arbiter.sv
      - wb_slave_decoder.sv
      - sram_slave.sv
      - gpio_slave.sv
      - soc_fabric_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_soc_fabric_top.sv

// ==== gpio_slave.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "soc_macros.svh"

module gpio_slave import soc_pkg::*; (
   input  logic              wb_clk_i,
   input  logic              rst_n_i,
   input  wb_req_t           req_i,
   output wb_rsp_t           rsp_o,
   // Pad side with the tri-state outside
   input  logic [`GPIO_W-1:0] gpio_in_i,
   output logic [`GPIO_W-1:0] gpio_out_o,
   output logic [`GPIO_W-1:0] gpio_oe_o
);

   logic [`GPIO_W-1:0]     in_meta_q;
   logic [`GPIO_W-1:0]     in_sync_q;
   logic [`GPIO_W-1:0]     out_q;
   logic [`GPIO_W-1:0]     oe_q;
   logic [`SOC_DATA_W-1:0] rdata_q;
   logic [7:0]             ofs;
   logic                   access;
   logic                   ack_q;
   logic                   err_q;

   // Byte-lane merge of write data into a register
   function automatic logic [`GPIO_W-1:0] merge_lanes(
      input logic [`GPIO_W-1:0]     old_val,
      input logic [`SOC_DATA_W-1:0] wdata,
      input logic [`SOC_SEL_W-1:0]  sel
   );
      logic [`GPIO_W-1:0] res;
      res = old_val;
      for (int b = 0; b < `SOC_SEL_W; b++) begin
         if (sel[b]) begin
            res[8*b +: 8] = wdata[8*b +: 8];
         end
      end
      return res;
   endfunction

   // Register offset from the low byte of the page
   assign ofs    = req_i.adr[7:0];
   assign access = req_i.cyc && req_i.stb && !(ack_q || err_q);

   // ------------------------------------------------------------------------
   // Input sync, OUT/OE registers, termination
   // ------------------------------------------------------------------------
   always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         in_meta_q <= '0;
         in_sync_q <= '0;
         out_q     <= '0;
         oe_q      <= '0;
         ack_q     <= 1'b0;
         err_q     <= 1'b0;
      end else begin
         // Two flops against metastability
         in_meta_q <= gpio_in_i;
         in_sync_q <= in_meta_q;
         ack_q     <= 1'b0;
         err_q     <= 1'b0;
         if (access) begin
            case (ofs)
               // IN is read only
               `GPIO_OFS_IN: begin
                  err_q <= req_i.we;
                  ack_q <= !req_i.we;
               end
               `GPIO_OFS_OUT: begin
                  ack_q <= 1'b1;
                  if (req_i.we) out_q <= merge_lanes(out_q, req_i.dat, req_i.sel);
               end
               `GPIO_OFS_OE: begin
                  ack_q <= 1'b1;
                  if (req_i.we) oe_q <= merge_lanes(oe_q, req_i.dat, req_i.sel);
               end
               default: err_q <= 1'b1;
            endcase
         end
      end
   end

   // Read data capture
   always_ff @(posedge wb_clk_i) begin
      if (access) begin
         case (ofs)
            `GPIO_OFS_IN:  rdata_q <= in_sync_q;
            `GPIO_OFS_OUT: rdata_q <= out_q;
            `GPIO_OFS_OE:  rdata_q <= oe_q;
            default:       rdata_q <= '0;
         endcase
      end
   end

   assign rsp_o      = '{ack: ack_q, err: err_q, dat: rdata_q};
   assign gpio_out_o = out_q;
   assign gpio_oe_o  = oe_q;

endmodule

`default_nettype wire

// ==== soc_fabric_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "soc_macros.svh"

module soc_fabric_top import soc_pkg::*; (
   input  logic               wb_clk_i,
   input  logic               rst_n_i,
   // Processor data port
   input  wb_req_t            cpu_req_i,
   output wb_rsp_t            cpu_rsp_o,
   // Debug port
   input  wb_req_t            dbg_req_i,
   output wb_rsp_t            dbg_rsp_o,
   // GPIO pins with the pad tri-state outside
   input  logic [`GPIO_W-1:0] gpio_in_i,
   output logic [`GPIO_W-1:0] gpio_out_o,
   output logic [`GPIO_W-1:0] gpio_oe_o
);

   // ------------------------------------------------------------------------
   // Internal buses
   // ------------------------------------------------------------------------
   wb_req_t mst_req;
   wb_rsp_t mst_rsp;
   wb_req_t sram_req;
   wb_rsp_t sram_rsp;
   wb_req_t gpio_req;
   wb_rsp_t gpio_rsp;

   // Two masters onto one bus
   wb_rr_arbiter u_arb (
      .wb_clk_i  (wb_clk_i),
      .rst_n_i   (rst_n_i),
      .cpu_req_i (cpu_req_i),
      .cpu_rsp_o (cpu_rsp_o),
      .dbg_req_i (dbg_req_i),
      .dbg_rsp_o (dbg_rsp_o),
      .mst_req_o (mst_req),
      .mst_rsp_i (mst_rsp)
   );

   // Page decode
   wb_slave_decoder u_dec (
      .wb_clk_i   (wb_clk_i),
      .rst_n_i    (rst_n_i),
      .mst_req_i  (mst_req),
      .mst_rsp_o  (mst_rsp),
      .sram_req_o (sram_req),
      .sram_rsp_i (sram_rsp),
      .gpio_req_o (gpio_req),
      .gpio_rsp_i (gpio_rsp)
   );

   // Slot 14
   sram_slave u_sram (
      .wb_clk_i (wb_clk_i),
      .rst_n_i  (rst_n_i),
      .req_i    (sram_req),
      .rsp_o    (sram_rsp)
   );

   // Slot 4
   gpio_slave u_gpio (
      .wb_clk_i   (wb_clk_i),
      .rst_n_i    (rst_n_i),
      .req_i      (gpio_req),
      .rsp_o      (gpio_rsp),
      .gpio_in_i  (gpio_in_i),
      .gpio_out_o (gpio_out_o),
      .gpio_oe_o  (gpio_oe_o)
   );

endmodule

`default_nettype wire

// ==== soc_macros.svh ====
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// ---------------------------------------------------------------------------
// Bus widths
// ---------------------------------------------------------------------------
`define SOC_DATA_W     32
`define SOC_ADDR_W     32
`define SOC_SEL_W      4

// Internal SRAM word index width, 256 words
`define SRAM_AW_WORDS  8

// ---------------------------------------------------------------------------
// Slave pages on address bits 31:28
// ---------------------------------------------------------------------------
`define SLV_PAGE_SRAM  4'hE
`define SLV_PAGE_GPIO  4'h4

// ---------------------------------------------------------------------------
// GPIO block
// ---------------------------------------------------------------------------
`define GPIO_W         32

// Register byte offsets within the GPIO page
`define GPIO_OFS_IN    8'h00
`define GPIO_OFS_OUT   8'h04
`define GPIO_OFS_OE    8'h08

`endif

// ==== soc_pkg.sv ====
`default_nettype none

package soc_pkg;

   `include "soc_macros.svh"

   // ------------------------------------------------------------------------
   // Wishbone classic request, master to slave
   // ------------------------------------------------------------------------
   typedef struct packed {
      logic                   cyc;
      logic                   stb;
      logic                   we;
      logic [`SOC_ADDR_W-1:0] adr;
      logic [`SOC_SEL_W-1:0]  sel;
      logic [`SOC_DATA_W-1:0] dat;
   } wb_req_t;

   // Wishbone classic response, slave to master
   typedef struct packed {
      logic                   ack;
      logic                   err;
      logic [`SOC_DATA_W-1:0] dat;
   } wb_rsp_t;

   // ------------------------------------------------------------------------
   // Arbiter grant state
   // ------------------------------------------------------------------------
   typedef enum logic [1:0] {
      ARB_IDLE = 2'd0,
      ARB_CPU  = 2'd1,
      ARB_DBG  = 2'd2
   } arb_state_e;

   // Decoded slave target
   typedef enum logic [1:0] {
      SEL_SRAM = 2'd0,
      SEL_GPIO = 2'd1,
      SEL_NONE = 2'd2
   } slave_sel_e;

endpackage

`default_nettype wire

// ==== sources.f ====
+incdir+.
soc_pkg.sv
wb_rr_arbiter.sv
wb_slave_decoder.sv
sram_slave.sv
gpio_slave.sv
soc_fabric_top.sv
tb_soc_fabric_top.sv

// ==== sram_slave.sv ====
`timescale 1ns/10ps
`default_nettype none

module sram_slave import soc_pkg::*; (
   input  logic    wb_clk_i,
   input  logic    rst_n_i,
   input  wb_req_t req_i,
   output wb_rsp_t rsp_o
);

   `include "soc_macros.svh"

   localparam int unsigned DEPTH = 1 << `SRAM_AW_WORDS;

   logic [`SOC_DATA_W-1:0]    mem_q [DEPTH];
   logic [`SOC_DATA_W-1:0]    rdata_q;
   logic [`SRAM_AW_WORDS-1:0] word_idx;
   logic                      access;
   logic                      ack_q;

   // Word index from bits 9:2, higher page bits alias
   assign word_idx = req_i.adr[`SRAM_AW_WORDS+1:2];

   // New access only when the previous ack has gone
   assign access = req_i.cyc && req_i.stb && !ack_q;

   // ------------------------------------------------------------------------
   // Storage with byte-lane writes
   // ------------------------------------------------------------------------
   always_ff @(posedge wb_clk_i) begin
      if (access) begin
         if (req_i.we) begin
            for (int b = 0; b < `SOC_SEL_W; b++) begin
               if (req_i.sel[b]) begin
                  mem_q[word_idx][8*b +: 8] <= req_i.dat[8*b +: 8];
               end
            end
         end
         // Old word on a write, read data on a read
         rdata_q <= mem_q[word_idx];
      end
   end

   // Single-cycle ack
   always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   assign rsp_o = '{ack: ack_q, err: 1'b0, dat: rdata_q};

   // Held strobe must not produce a second ack back to back
   assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
      (rsp_o.ack && req_i.stb) |=> !(rsp_o.ack && req_i.stb));

endmodule

`default_nettype wire

// ==== tb_soc_fabric_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "soc_macros.svh"

module tb_soc_fabric_top import soc_pkg::*; ();

   localparam int TIMEOUT = 50;

   logic               clk;
   logic               rst_n;
   wb_req_t            cpu_req;
   wb_rsp_t            cpu_rsp;
   wb_req_t            dbg_req;
   wb_rsp_t            dbg_rsp;
   logic [`GPIO_W-1:0] gpio_in;
   logic [`GPIO_W-1:0] gpio_out;
   logic [`GPIO_W-1:0] gpio_oe;

   // Reference model state
   logic [31:0]        sram_ref [256];
   logic [31:0]        out_ref;
   logic [31:0]        oe_ref;
   logic [31:0]        in_ref;

   int                 errors;
   int                 checks;
   // Completions seen while the other port had cyc up
   int                 cpu_overlap;
   int                 dbg_overlap;

   soc_fabric_top UUT (
      .wb_clk_i   (clk),
      .rst_n_i    (rst_n),
      .cpu_req_i  (cpu_req),
      .cpu_rsp_o  (cpu_rsp),
      .dbg_req_i  (dbg_req),
      .dbg_rsp_o  (dbg_rsp),
      .gpio_in_i  (gpio_in),
      .gpio_out_o (gpio_out),
      .gpio_oe_o  (gpio_oe)
   );

   // 20 ns clock
   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // -------------------------------------------------------------------------
   // Reference model
   // -------------------------------------------------------------------------
   function automatic logic [31:0] apply_byte_enables(
      input logic [31:0] old_val,
      input logic [31:0] wdat,
      input logic [3:0]  sel
   );
      logic [31:0] res;
      res = old_val;
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) res[8*b +: 8] = wdat[8*b +: 8];
      end
      return res;
   endfunction

   // Bit 32 is the expected err, bits 31:0 the expected read data
   function automatic logic [32:0] expected_response(input logic [31:0] adr, input logic we);
      logic [32:0] r;
      r = '0;
      case (adr[31:28])
         `SLV_PAGE_SRAM: r[31:0] = sram_ref[adr[9:2]];
         `SLV_PAGE_GPIO: begin
            case (adr[7:0])
               `GPIO_OFS_IN: begin
                  r[32]   = we;
                  r[31:0] = in_ref;
               end
               `GPIO_OFS_OUT: r[31:0] = out_ref;
               `GPIO_OFS_OE:  r[31:0] = oe_ref;
               default:       r[32] = 1'b1;
            endcase
         end
         default: r[32] = 1'b1;
      endcase
      return r;
   endfunction

   task automatic update_model(input logic [31:0] adr, input logic [3:0] sel,
                               input logic [31:0] wdat);
      if (adr[31:28] == `SLV_PAGE_SRAM) begin
         sram_ref[adr[9:2]] = apply_byte_enables(sram_ref[adr[9:2]], wdat, sel);
      end else if (adr[7:0] == `GPIO_OFS_OUT) begin
         out_ref = apply_byte_enables(out_ref, wdat, sel);
      end else if (adr[7:0] == `GPIO_OFS_OE) begin
         oe_ref = apply_byte_enables(oe_ref, wdat, sel);
      end
   endtask

   // SRAM address with random upper page bits, exercises aliasing
   function automatic logic [31:0] sram_addr(input logic [7:0] word);
      return {`SLV_PAGE_SRAM, 18'($urandom()), word, 2'b00};
   endfunction

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // -------------------------------------------------------------------------
   // Bus tasks, one per master
   // -------------------------------------------------------------------------
   task automatic cpu_bus_xfer(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                               input logic [31:0] wdat, output logic [31:0] rdat,
                               output logic ack, output logic err, output logic ok);
      int n;
      n  = 0;
      ok = 1'b0;
      @(posedge clk);
      cpu_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: wdat};
      // Sample on the falling edge where the response is settled
      while (!ok && n < TIMEOUT) begin
         @(negedge clk);
         if (cpu_rsp.ack || cpu_rsp.err) begin
            ok   = 1'b1;
            ack  = cpu_rsp.ack;
            err  = cpu_rsp.err;
            rdat = cpu_rsp.dat;
            if (dbg_req.cyc) cpu_overlap++;
         end
         n++;
      end
      @(posedge clk);
      cpu_req <= '0;
      if (!ok) begin
         errors++;
         $display("Timeout: no ack or err on the processor port for address %h", adr);
      end
   endtask

   task automatic dbg_bus_xfer(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                               input logic [31:0] wdat, output logic [31:0] rdat,
                               output logic ack, output logic err, output logic ok);
      int n;
      n  = 0;
      ok = 1'b0;
      @(posedge clk);
      dbg_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: wdat};
      while (!ok && n < TIMEOUT) begin
         @(negedge clk);
         if (dbg_rsp.ack || dbg_rsp.err) begin
            ok   = 1'b1;
            ack  = dbg_rsp.ack;
            err  = dbg_rsp.err;
            rdat = dbg_rsp.dat;
            if (cpu_req.cyc) dbg_overlap++;
         end
         n++;
      end
      @(posedge clk);
      dbg_req <= '0;
      if (!ok) begin
         errors++;
         $display("Timeout: no ack or err on the debug port for address %h", adr);
      end
   endtask

   // One access on master m (0 processor, 1 debug), compared with the model
   task automatic access_and_compare(input int m, input logic we, input logic [31:0] adr,
                                     input logic [3:0] sel, input logic [31:0] wdat);
      logic [32:0] exp;
      logic [31:0] rdat;
      logic        ack;
      logic        err;
      logic        ok;
      string       pfx;
      pfx = (m == 0) ? "cpu_rsp_o" : "dbg_rsp_o";
      exp = expected_response(adr, we);
      if (m == 0) cpu_bus_xfer(we, adr, sel, wdat, rdat, ack, err, ok);
      else        dbg_bus_xfer(we, adr, sel, wdat, rdat, ack, err, ok);
      if (ok) begin
         compare_value({pfx, ".ack"}, 32'(ack), 32'(!exp[32]));
         compare_value({pfx, ".err"}, 32'(err), 32'(exp[32]));
         if (!we && !exp[32]) compare_value({pfx, ".dat"}, rdat, exp[31:0]);
      end
      if (we && !exp[32]) update_model(adr, sel, wdat);
   endtask

   task automatic random_sram_txn(input int m);
      logic [7:0] w;
      logic       we;
      // Processor keeps to words 0..127, debug to 128..255
      w  = {m[0], 7'($urandom_range(127))};
      we = 1'($urandom_range(1));
      access_and_compare(m, we, sram_addr(w), 4'($urandom()), $urandom());
   endtask

   // -------------------------------------------------------------------------
   // Test sequence
   // -------------------------------------------------------------------------
   initial begin
      logic [31:0] v;
      void'($urandom(32'h1658_ec83));
      errors      = 0;
      checks      = 0;
      cpu_overlap = 0;
      dbg_overlap = 0;
      out_ref     = '0;
      oe_ref      = '0;
      in_ref      = '0;
      rst_n       = 1'b0;
      cpu_req     = '0;
      dbg_req     = '0;
      gpio_in     = '0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;

      // Idle state after reset
      @(negedge clk);
      compare_value("cpu_rsp_o.ack/err", 32'({cpu_rsp.ack, cpu_rsp.err}), 32'h0);
      compare_value("dbg_rsp_o.ack/err", 32'({dbg_rsp.ack, dbg_rsp.err}), 32'h0);
      compare_value("gpio_out_o", gpio_out, 32'h0);
      compare_value("gpio_oe_o", gpio_oe, 32'h0);

      // SRAM fill, then random partial writes and aliased read-back
      for (int i = 0; i < 256; i++) access_and_compare(0, 1'b1, sram_addr(8'(i)), 4'hF, $urandom());
      repeat (80) random_sram_txn(0);
      for (int i = 0; i < 256; i += 5) access_and_compare(0, 1'b0, sram_addr(8'(i)), 4'hF, '0);

      // GPIO OUT and OE from both ports
      access_and_compare(0, 1'b1, 32'h4000_0004, 4'hF, $urandom());
      @(negedge clk);
      compare_value("gpio_out_o", gpio_out, out_ref);
      access_and_compare(1, 1'b1, 32'h4000_0008, 4'hF, $urandom());
      access_and_compare(1, 1'b1, 32'h4000_0004, 4'b0101, $urandom());
      @(negedge clk);
      compare_value("gpio_oe_o", gpio_oe, oe_ref);
      compare_value("gpio_out_o", gpio_out, out_ref);
      access_and_compare(0, 1'b0, 32'h4000_0008, 4'hF, '0);
      access_and_compare(1, 1'b0, 32'h4000_0004, 4'hF, '0);

      // Input held through the synchronizer, then read
      v = $urandom();
      @(posedge clk);
      gpio_in <= v;
      in_ref = v;
      repeat (3) @(posedge clk);
      access_and_compare(1, 1'b0, 32'h4000_0000, 4'hF, '0);

      // Error paths, each followed by a good access
      access_and_compare(0, 1'b0, 32'h2000_0010, 4'hF, '0);
      access_and_compare(0, 1'b0, sram_addr(8'h11), 4'hF, '0);
      access_and_compare(1, 1'b1, 32'h4000_0000, 4'hF, $urandom());
      access_and_compare(1, 1'b0, 32'h4000_0004, 4'hF, '0);
      access_and_compare(0, 1'b1, 32'h4000_000C, 4'hF, $urandom());
      access_and_compare(0, 1'b0, 32'h4000_0008, 4'hF, '0);

      // Both masters at once on disjoint SRAM halves
      cpu_overlap = 0;
      dbg_overlap = 0;
      fork
         for (int k = 0; k < 40; k++) random_sram_txn(0);
         for (int k = 0; k < 40; k++) random_sram_txn(1);
      join
      if (cpu_overlap == 0 || dbg_overlap == 0) begin
         errors++;
         $display("A port never completed a transfer while the other port was waiting");
      end

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== wb_rr_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_rr_arbiter import soc_pkg::*; (
   input  logic    wb_clk_i,
   input  logic    rst_n_i,
   // Processor data port
   input  wb_req_t cpu_req_i,
   output wb_rsp_t cpu_rsp_o,
   // Debug port
   input  wb_req_t dbg_req_i,
   output wb_rsp_t dbg_rsp_o,
   // Shared bus towards the decoder
   output wb_req_t mst_req_o,
   input  wb_rsp_t mst_rsp_i
);

   arb_state_e state_q;
   arb_state_e state_d;
   // High when the debug port held the last grant
   logic       last_dbg_q;

   // ------------------------------------------------------------------------
   // Next grant
   // ------------------------------------------------------------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         ARB_IDLE: begin
            // Tie goes to the master not served last
            if (cpu_req_i.cyc && dbg_req_i.cyc) begin
               state_d = last_dbg_q ? ARB_CPU : ARB_DBG;
            end else if (cpu_req_i.cyc) begin
               state_d = ARB_CPU;
            end else if (dbg_req_i.cyc) begin
               state_d = ARB_DBG;
            end
         end
         // Grant held for as long as cyc stays up
         ARB_CPU: begin
            if (!cpu_req_i.cyc) begin
               state_d = ARB_IDLE;
            end
         end
         ARB_DBG: begin
            if (!dbg_req_i.cyc) begin
               state_d = ARB_IDLE;
            end
         end
         default: state_d = ARB_IDLE;
      endcase
   end

   always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q    <= ARB_IDLE;
         // Processor wins the first tie
         last_dbg_q <= 1'b1;
      end else begin
         state_q <= state_d;
         if (state_q == ARB_IDLE && state_d == ARB_CPU) begin
            last_dbg_q <= 1'b0;
         end else if (state_q == ARB_IDLE && state_d == ARB_DBG) begin
            last_dbg_q <= 1'b1;
         end
      end
   end

   // ------------------------------------------------------------------------
   // Request mux and response steering
   // ------------------------------------------------------------------------
   always_comb begin
      mst_req_o = '0;
      cpu_rsp_o = '0;
      dbg_rsp_o = '0;
      case (state_q)
         ARB_CPU: begin
            mst_req_o = cpu_req_i;
            cpu_rsp_o = mst_rsp_i;
         end
         ARB_DBG: begin
            mst_req_o = dbg_req_i;
            dbg_rsp_o = mst_rsp_i;
         end
         default: ;
      endcase
   end

   // Slave answer only ever lands on a master with an open cycle
   assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
      ((cpu_rsp_o.ack || cpu_rsp_o.err) |-> cpu_req_i.cyc) and
      ((dbg_rsp_o.ack || dbg_rsp_o.err) |-> dbg_req_i.cyc));

endmodule

`default_nettype wire

// ==== wb_slave_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_slave_decoder import soc_pkg::*; (
   input  logic    wb_clk_i,
   input  logic    rst_n_i,
   // Granted master
   input  wb_req_t mst_req_i,
   output wb_rsp_t mst_rsp_o,
   // Internal SRAM, page 14
   output wb_req_t sram_req_o,
   input  wb_rsp_t sram_rsp_i,
   // GPIO, page 4
   output wb_req_t gpio_req_o,
   input  wb_rsp_t gpio_rsp_i
);

   `include "soc_macros.svh"

   slave_sel_e sel;
   // One-cycle err for unmapped pages
   logic       err_q;

   // ------------------------------------------------------------------------
   // Page decode on the top address nibble
   // ------------------------------------------------------------------------
   always_comb begin
      case (mst_req_i.adr[`SOC_ADDR_W-1 -: 4])
         `SLV_PAGE_SRAM: sel = SEL_SRAM;
         `SLV_PAGE_GPIO: sel = SEL_GPIO;
         default:        sel = SEL_NONE;
      endcase
   end

   // ------------------------------------------------------------------------
   // Request fan-out
   // ------------------------------------------------------------------------
   always_comb begin
      sram_req_o = mst_req_i;
      gpio_req_o = mst_req_i;
      // Strobe only towards the selected slave
      sram_req_o.stb = mst_req_i.stb && (sel == SEL_SRAM);
      gpio_req_o.stb = mst_req_i.stb && (sel == SEL_GPIO);
   end

   // Unmapped slots answer with err, like the tied-off interconnect slots
   always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= mst_req_i.cyc && mst_req_i.stb && (sel == SEL_NONE) && !err_q;
      end
   end

   // ------------------------------------------------------------------------
   // Response mux
   // ------------------------------------------------------------------------
   always_comb begin
      case (sel)
         SEL_SRAM: mst_rsp_o = sram_rsp_i;
         SEL_GPIO: mst_rsp_o = gpio_rsp_i;
         default: begin
            mst_rsp_o     = '0;
            mst_rsp_o.err = err_q;
         end
      endcase
   end

   // Both terminations at once would confuse the master
   assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
      !(mst_rsp_o.ack && mst_rsp_o.err));

endmodule

`default_nettype wire
